// File: vbe_macros.svh
`ifndef VBE_MACROS_SVH
`define VBE_MACROS_SVH

// Lane geometry
`define VBE_LANES    4
`define VBE_LANE_W   8

// Full register width, lanes times lane width
`define VBE_VLEN     32

// Architectural vector registers
`define VBE_NREG     8

// Command queue entries, kept a power of two so pointers wrap
`define VBE_CQ_DEPTH 4

// Instruction word
`define VBE_INST_W   16

`endif

// File: vbe_pkg.sv
`include "vbe_macros.svh"

package vbe_pkg;

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSADDU = 3'd1,
    VSUB   = 3'd2,
    VAND   = 3'd3,
    VMV_I  = 3'd4,
    VADD_I = 3'd5
  } vop_e;

  // Register-register form
  typedef struct packed {
    vop_e       funct;
    logic       lmul2;
    logic [2:0] vd;
    logic [2:0] vs2;
    logic [2:0] rsvd;
    logic [2:0] vs1;
  } vinst_vv_t;

  // Immediate form, low six bits are a signed immediate
  typedef struct packed {
    vop_e              funct;
    logic              lmul2;
    logic [2:0]        vd;
    logic [2:0]        vs2;
    logic signed [5:0] imm;
  } vinst_vi_t;

  // The opcode picks which view applies to the low bits
  typedef union packed {
    vinst_vv_t vv;
    vinst_vi_t vi;
  } vinst_u;

  typedef struct packed {
    vop_e                   op;
    logic [2:0]             vd;
    logic [2:0]             vs1;
    logic [2:0]             vs2;
    logic                   use_vs1;
    logic [`VBE_LANE_W-1:0] imm;
  } uop_t;

endpackage

// File: uop_if.sv
`timescale 1ns/100ps

interface uop_if;
  import vbe_pkg::*;

  logic valid;
  logic ready;
  uop_t uop;

  // Producer side
  modport src (
    output valid,
    output uop,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  uop,
    output ready
  );

endinterface

// File: cmd_queue.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module cmd_queue (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid_i,
  input  vbe_pkg::vinst_u in_data_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  output vbe_pkg::vinst_u out_data_o,
  input  logic            out_ready_i
);
  import vbe_pkg::*;

  vinst_u                               mem [`VBE_CQ_DEPTH];
  logic [$clog2(`VBE_CQ_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(`VBE_CQ_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(`VBE_CQ_DEPTH+1)-1:0]   count;
  logic                                 full;
  logic                                 push;
  logic                                 pop;

  assign full        = (count == `VBE_CQ_DEPTH);
  // A full queue still takes an entry when the head leaves this cycle
  assign in_ready_o  = !full || out_ready_i;
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: uop_decode.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module uop_decode (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            inst_valid_i,
  input  vbe_pkg::vinst_u inst_i,
  output logic            inst_ready_o,
  uop_if.src              uop_o
);
  import vbe_pkg::*;

  logic half;
  logic is_imm;
  logic can_load;
  logic load;
  logic last;
  uop_t uop_d;

  // Immediate opcodes read the low bits through the vi view
  assign is_imm   = (inst_i.vv.funct == VMV_I) || (inst_i.vv.funct == VADD_I);
  assign can_load = !uop_o.valid || uop_o.ready;
  assign load     = can_load && inst_valid_i;
  assign last     = !inst_i.vv.lmul2 || half;

  // Queue head is popped together with the last micro-op
  assign inst_ready_o = can_load && last;

  always_comb begin
    uop_d.op      = inst_i.vv.funct;
    uop_d.vd      = inst_i.vv.vd + {2'b00, half};
    uop_d.vs2     = inst_i.vv.vs2 + {2'b00, half};
    uop_d.use_vs1 = !is_imm;
    if (is_imm) begin
      uop_d.vs1 = '0;
      // Sign-extend to one lane
      uop_d.imm = {{(`VBE_LANE_W-6){inst_i.vi.imm[5]}}, inst_i.vi.imm};
    end else begin
      uop_d.vs1 = inst_i.vv.vs1 + {2'b00, half};
      uop_d.imm = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_o.valid <= 1'b0;
      half        <= 1'b0;
    end else begin
      if (can_load) begin
        uop_o.valid <= inst_valid_i;
      end
      // Second half follows only for LMUL=2
      if (load) begin
        half <= inst_i.vv.lmul2 && !half;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      uop_o.uop <= uop_d;
    end
  end

endmodule

// File: vec_issue.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module vec_issue (
  input  logic                 clk,
  input  logic                 rst_n,
  uop_if.dst                   uop_i,
  output logic [2:0]           rd_addr_a_o,
  output logic [2:0]           rd_addr_b_o,
  input  logic [`VBE_VLEN-1:0] rd_data_a_i,
  input  logic [`VBE_VLEN-1:0] rd_data_b_i,
  input  logic                 wb_valid_i,
  input  logic [2:0]           wb_vd_i,
  output logic                 alu_valid_o,
  output vbe_pkg::vop_e        alu_op_o,
  output logic [2:0]           alu_vd_o,
  output logic [`VBE_VLEN-1:0] alu_a_o,
  output logic [`VBE_VLEN-1:0] alu_b_o,
  input  logic                 alu_ready_i
);
  import vbe_pkg::*;

  uop_t                 cur;
  logic [`VBE_NREG-1:0] pending;
  logic [`VBE_NREG-1:0] set_mask;
  logic [`VBE_NREG-1:0] clr_mask;
  logic                 hazard;
  logic                 issue;

  assign cur = uop_i.uop;

  // RAW on the sources, WAW on the destination
  assign hazard = pending[cur.vd] || pending[cur.vs2] ||
                  (cur.use_vs1 && pending[cur.vs1]);

  assign alu_valid_o = uop_i.valid && !hazard;
  assign uop_i.ready = alu_ready_i && !hazard;
  assign issue       = alu_valid_o && alu_ready_i;

  assign rd_addr_a_o = cur.vs2;
  assign rd_addr_b_o = cur.vs1;
  assign alu_op_o    = cur.op;
  assign alu_vd_o    = cur.vd;
  assign alu_a_o     = rd_data_a_i;
  // Immediate forms see the immediate broadcast to every lane
  assign alu_b_o     = cur.use_vs1 ? rd_data_b_i : {`VBE_LANES{cur.imm}};

  assign set_mask = issue ? (`VBE_NREG'(1) << cur.vd) : '0;
  assign clr_mask = wb_valid_i ? (`VBE_NREG'(1) << wb_vd_i) : '0;

  // Set at issue, cleared when the result is written back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | set_mask;
    end
  end

endmodule

// File: vec_regfile.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module vec_regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [2:0]           rd_addr_a_i,
  output logic [`VBE_VLEN-1:0] rd_data_a_o,
  input  logic [2:0]           rd_addr_b_i,
  output logic [`VBE_VLEN-1:0] rd_data_b_o,
  input  logic                 wr_en_i,
  input  logic [2:0]           wr_addr_i,
  input  logic [`VBE_VLEN-1:0] wr_data_i
);

  logic [`VBE_VLEN-1:0] regs [`VBE_NREG];

  // Reads are combinational
  assign rd_data_a_o = regs[rd_addr_a_i];
  assign rd_data_b_o = regs[rd_addr_b_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `VBE_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

// File: vec_alu.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module vec_alu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  vbe_pkg::vop_e        in_op_i,
  input  logic [2:0]           in_vd_i,
  input  logic [`VBE_VLEN-1:0] in_a_i,
  input  logic [`VBE_VLEN-1:0] in_b_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output logic [2:0]           out_vd_o,
  output logic [`VBE_VLEN-1:0] out_data_o,
  output logic                 out_sat_o,
  input  logic                 out_ready_i
);
  import vbe_pkg::*;

  logic                  stall;
  logic [`VBE_VLEN-1:0]  lane_res;
  logic [`VBE_LANES-1:0] lane_sat;
  logic                  s1_valid;
  logic [2:0]            s1_vd;
  logic [`VBE_VLEN-1:0]  s1_res;
  logic [`VBE_LANES-1:0] s1_sat;

  // Unaccepted output freezes both stages
  assign stall      = out_valid_o && !out_ready_i;
  assign in_ready_o = !stall;

  always_comb begin
    logic [`VBE_LANE_W-1:0] a;
    logic [`VBE_LANE_W-1:0] b;
    logic [`VBE_LANE_W:0]   sum;
    for (int i = 0; i < `VBE_LANES; i++) begin
      a   = in_a_i[i*`VBE_LANE_W +: `VBE_LANE_W];
      b   = in_b_i[i*`VBE_LANE_W +: `VBE_LANE_W];
      sum = {1'b0, a} + {1'b0, b};
      lane_sat[i] = 1'b0;
      case (in_op_i)
        VADD, VADD_I: lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] = sum[`VBE_LANE_W-1:0];
        VSADDU: begin
          // Clamp to all ones on carry out
          lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] =
            sum[`VBE_LANE_W] ? {`VBE_LANE_W{1'b1}} : sum[`VBE_LANE_W-1:0];
          lane_sat[i] = sum[`VBE_LANE_W];
        end
        VSUB:    lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] = a - b;
        VAND:    lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] = a & b;
        VMV_I:   lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] = b;
        default: lane_res[i*`VBE_LANE_W +: `VBE_LANE_W] = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      out_valid_o <= 1'b0;
    end else if (!stall) begin
      s1_valid    <= in_valid_i;
      out_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_vd      <= in_vd_i;
      s1_res     <= lane_res;
      s1_sat     <= lane_sat;
      out_vd_o   <= s1_vd;
      out_data_o <= s1_res;
      // Any saturated lane flags the whole result
      out_sat_o  <= |s1_sat;
    end
  end

endmodule

// File: vec_retire.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module vec_retire (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  logic [2:0]           in_vd_i,
  input  logic [`VBE_VLEN-1:0] in_data_i,
  input  logic                 in_sat_i,
  output logic                 in_ready_o,
  output logic                 wr_en_o,
  output logic [2:0]           wr_addr_o,
  output logic [`VBE_VLEN-1:0] wr_data_o,
  output logic                 rt_valid_o,
  output logic [2:0]           rt_vd_o,
  output logic [`VBE_VLEN-1:0] rt_data_o,
  output logic                 rt_sat_o,
  input  logic                 rt_ready_i,
  output logic                 vxsat_o,
  input  logic                 vxsat_clr_i
);

  logic accept;

  // A held report blocks the ALU
  assign in_ready_o = !rt_valid_o || rt_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  // Write-back happens on the same edge that loads the report
  assign wr_en_o   = accept;
  assign wr_addr_o = in_vd_i;
  assign wr_data_o = in_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_valid_o <= 1'b0;
      vxsat_o    <= 1'b0;
    end else begin
      if (accept) begin
        rt_valid_o <= 1'b1;
      end else if (rt_ready_i) begin
        rt_valid_o <= 1'b0;
      end
      // Set wins over a clear in the same cycle
      if (accept && in_sat_i) begin
        vxsat_o <= 1'b1;
      end else if (vxsat_clr_i) begin
        vxsat_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rt_vd_o   <= in_vd_i;
      rt_data_o <= in_data_i;
      rt_sat_o  <= in_sat_i;
    end
  end

endmodule

// File: vec_backend.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module vec_backend (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inst_valid_i,
  input  logic [`VBE_INST_W-1:0] inst_i,
  output logic                   inst_ready_o,
  output logic                   rt_valid_o,
  output logic [2:0]             rt_vd_o,
  output logic [`VBE_VLEN-1:0]   rt_data_o,
  output logic                   rt_sat_o,
  input  logic                   rt_ready_i,
  output logic                   vxsat_o,
  input  logic                   vxsat_clr_i
);
  import vbe_pkg::*;

  // Queue to decode
  logic                 cq_valid;
  vinst_u               cq_data;
  logic                 cq_ready;

  // Register file ports
  logic [2:0]           rd_addr_a;
  logic [2:0]           rd_addr_b;
  logic [`VBE_VLEN-1:0] rd_data_a;
  logic [`VBE_VLEN-1:0] rd_data_b;
  logic                 wb_en;
  logic [2:0]           wb_vd;
  logic [`VBE_VLEN-1:0] wb_data;

  // Issue to ALU
  logic                 iss_valid;
  vop_e                 iss_op;
  logic [2:0]           iss_vd;
  logic [`VBE_VLEN-1:0] iss_a;
  logic [`VBE_VLEN-1:0] iss_b;
  logic                 iss_ready;

  // ALU to retire
  logic                 alu_valid;
  logic [2:0]           alu_vd;
  logic [`VBE_VLEN-1:0] alu_data;
  logic                 alu_sat;
  logic                 alu_ready;

  uop_if dec2iss ();

  cmd_queue u_cmd_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (inst_valid_i),
    .in_data_i   (inst_i),
    .in_ready_o  (inst_ready_o),
    .out_valid_o (cq_valid),
    .out_data_o  (cq_data),
    .out_ready_i (cq_ready)
  );

  uop_decode u_uop_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (cq_valid),
    .inst_i       (cq_data),
    .inst_ready_o (cq_ready),
    .uop_o        (dec2iss.src)
  );

  vec_issue u_vec_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .uop_i       (dec2iss.dst),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .wb_valid_i  (wb_en),
    .wb_vd_i     (wb_vd),
    .alu_valid_o (iss_valid),
    .alu_op_o    (iss_op),
    .alu_vd_o    (iss_vd),
    .alu_a_o     (iss_a),
    .alu_b_o     (iss_b),
    .alu_ready_i (iss_ready)
  );

  vec_regfile u_vec_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_addr_a_i (rd_addr_a),
    .rd_data_a_o (rd_data_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_b_o (rd_data_b),
    .wr_en_i     (wb_en),
    .wr_addr_i   (wb_vd),
    .wr_data_i   (wb_data)
  );

  vec_alu u_vec_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (iss_valid),
    .in_op_i     (iss_op),
    .in_vd_i     (iss_vd),
    .in_a_i      (iss_a),
    .in_b_i      (iss_b),
    .in_ready_o  (iss_ready),
    .out_valid_o (alu_valid),
    .out_vd_o    (alu_vd),
    .out_data_o  (alu_data),
    .out_sat_o   (alu_sat),
    .out_ready_i (alu_ready)
  );

  vec_retire u_vec_retire (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (alu_valid),
    .in_vd_i     (alu_vd),
    .in_data_i   (alu_data),
    .in_sat_i    (alu_sat),
    .in_ready_o  (alu_ready),
    .wr_en_o     (wb_en),
    .wr_addr_o   (wb_vd),
    .wr_data_o   (wb_data),
    .rt_valid_o  (rt_valid_o),
    .rt_vd_o     (rt_vd_o),
    .rt_data_o   (rt_data_o),
    .rt_sat_o    (rt_sat_o),
    .rt_ready_i  (rt_ready_i),
    .vxsat_o     (vxsat_o),
    .vxsat_clr_i (vxsat_clr_i)
  );

endmodule

// File: tb_vec_backend.sv
`timescale 1ns/100ps
`include "vbe_macros.svh"

module tb_vec_backend;
  import vbe_pkg::*;

  localparam int N_INST      = 300;
  localparam int CYCLE_LIMIT = 20 * N_INST + 100;

  logic                   clk;
  logic                   rst_n;
  logic                   inst_valid_i;
  logic [`VBE_INST_W-1:0] inst_i;
  logic                   inst_ready_o;
  logic                   rt_valid_o;
  logic [2:0]             rt_vd_o;
  logic [`VBE_VLEN-1:0]   rt_data_o;
  logic                   rt_sat_o;
  logic                   rt_ready_i;
  logic                   vxsat_o;
  logic                   vxsat_clr_i;

  // Expected reports in program order
  logic [2:0]           exp_vd[$];
  logic [`VBE_VLEN-1:0] exp_data[$];
  logic                 exp_sat[$];
  logic [`VBE_VLEN-1:0] model_regs [`VBE_NREG];

  logic [31:0]          rng_state = 32'd52269;
  int                   cycle_cnt = 0;
  int                   take_cnt = 0;
  int                   load_cnt = 0;
  logic                 mon_en = 1'b0;
  logic                 in_fire = 1'b0;
  logic                 saw_full = 1'b0;
  logic                 model_vxsat = 1'b0;
  logic                 prev_valid = 1'b0;
  logic                 prev_ready = 1'b0;
  logic                 prev_clr = 1'b0;
  logic                 new_rpt;
  logic                 sat_now;
  logic [2:0]           held_vd;
  logic [`VBE_VLEN-1:0] held_data;
  logic                 held_sat;

  vec_backend dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .inst_ready_o (inst_ready_o),
    .rt_valid_o   (rt_valid_o),
    .rt_vd_o      (rt_vd_o),
    .rt_data_o    (rt_data_o),
    .rt_sat_o     (rt_sat_o),
    .rt_ready_i   (rt_ready_i),
    .vxsat_o      (vxsat_o),
    .vxsat_clr_i  (vxsat_clr_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Early instructions lean on immediates so registers get filled
  function automatic logic [15:0] make_inst(input int idx);
    logic [31:0] r;
    logic [2:0]  op;
    logic [15:0] w;
    r = next_rand();
    if (idx < 20 && r[1:0] != 2'd0) begin
      op = r[2] ? 3'(VADD_I) : 3'(VMV_I);
    end else begin
      op = 3'(r[31:16] % 6);
    end
    w[15:13] = op;
    w[12]    = (r[5:4] == 2'd0);
    w[11:9]  = r[8:6];
    w[8:6]   = r[11:9];
    if (op == 3'(VMV_I) || op == 3'(VADD_I)) begin
      w[5:0] = r[17:12];
    end else begin
      w[5:3] = 3'd0;
      w[2:0] = r[14:12];
    end
    return w;
  endfunction

  // Executes one instruction in program order and queues its reports
  task automatic model_inst(input logic [15:0] w);
    vop_e                   op;
    logic                   is_imm;
    logic [2:0]             d;
    logic [2:0]             s1;
    logic [2:0]             s2;
    logic [`VBE_LANE_W-1:0] imm;
    logic [`VBE_LANE_W-1:0] la;
    logic [`VBE_LANE_W-1:0] lb;
    logic [`VBE_LANE_W:0]   sum;
    logic [`VBE_VLEN-1:0]   a;
    logic [`VBE_VLEN-1:0]   b;
    logic [`VBE_VLEN-1:0]   res;
    logic                   sat;
    int                     h;
    int                     l;
    op     = vop_e'(w[15:13]);
    is_imm = (op == VMV_I) || (op == VADD_I);
    imm    = {{(`VBE_LANE_W-6){w[5]}}, w[5:0]};
    for (h = 0; h <= int'(w[12]); h++) begin
      d   = w[11:9] + 3'(h);
      s2  = w[8:6] + 3'(h);
      s1  = w[2:0] + 3'(h);
      a   = model_regs[s2];
      b   = is_imm ? {`VBE_LANES{imm}} : model_regs[s1];
      sat = 1'b0;
      for (l = 0; l < `VBE_LANES; l++) begin
        la  = a[l*`VBE_LANE_W +: `VBE_LANE_W];
        lb  = b[l*`VBE_LANE_W +: `VBE_LANE_W];
        sum = la + lb;
        case (op)
          VSADDU: begin
            if (sum > 255) begin
              res[l*`VBE_LANE_W +: `VBE_LANE_W] = 8'hff;
              sat = 1'b1;
            end else begin
              res[l*`VBE_LANE_W +: `VBE_LANE_W] = sum[7:0];
            end
          end
          VSUB:    res[l*`VBE_LANE_W +: `VBE_LANE_W] = la - lb;
          VAND:    res[l*`VBE_LANE_W +: `VBE_LANE_W] = la & lb;
          VMV_I:   res[l*`VBE_LANE_W +: `VBE_LANE_W] = lb;
          default: res[l*`VBE_LANE_W +: `VBE_LANE_W] = sum[7:0];
        endcase
      end
      model_regs[d] = res;
      exp_vd.push_back(d);
      exp_data.push_back(res);
      exp_sat.push_back(sat);
    end
  endtask

  // Sampled mid-cycle, after the inputs have settled
  always @(negedge clk) begin
    if (mon_en) begin
      // A held report blocks the retire stage, otherwise a visible report is fresh
      new_rpt = rt_valid_o && !(prev_valid && !prev_ready);
      sat_now = 1'b0;
      if (new_rpt) begin
        if (load_cnt >= exp_sat.size()) begin
          fail_run("a report appeared with no micro-op left in the model");
        end
        sat_now = exp_sat[load_cnt];
        load_cnt++;
      end
      if (sat_now) begin
        model_vxsat = 1'b1;
      end else if (prev_clr) begin
        model_vxsat = 1'b0;
      end
      check_val("vxsat_o", vxsat_o, model_vxsat);
      if (prev_valid && !prev_ready) begin
        check_val("rt_valid_o", rt_valid_o, 1'b1);
        check_val("rt_vd_o", rt_vd_o, held_vd);
        check_val("rt_data_o", rt_data_o, held_data);
        check_val("rt_sat_o", rt_sat_o, held_sat);
      end
      if (rt_valid_o && rt_ready_i) begin
        if (take_cnt >= exp_vd.size()) begin
          fail_run("a report was taken with no micro-op left in the model");
        end
        check_val("rt_vd_o", rt_vd_o, exp_vd[take_cnt]);
        check_val("rt_data_o", rt_data_o, exp_data[take_cnt]);
        check_val("rt_sat_o", rt_sat_o, exp_sat[take_cnt]);
        take_cnt++;
      end
      if (inst_valid_i && !inst_ready_o) begin
        saw_full = 1'b1;
      end
      in_fire    = inst_valid_i && inst_ready_o;
      prev_valid = rt_valid_o;
      prev_ready = rt_ready_i;
      prev_clr   = vxsat_clr_i;
      held_vd    = rt_vd_o;
      held_data  = rt_data_o;
      held_sat   = rt_sat_o;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
        fail_run($sformatf("timeout after %0d cycles, %0d of %0d reports seen",
                           cycle_cnt, take_cnt, exp_vd.size()));
      end
    end
  end

  initial begin
    int          sent;
    int          made;
    int          stall_left;
    logic [15:0] w;
    sent         = 0;
    made         = 0;
    stall_left   = 0;
    rst_n        = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    rt_ready_i   = 1'b1;
    vxsat_clr_i  = 1'b0;
    for (int i = 0; i < `VBE_NREG; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_val("rt_valid_o", rt_valid_o, 1'b0);
    check_val("vxsat_o", vxsat_o, 1'b0);
    check_val("inst_ready_o", inst_ready_o, 1'b1);
    mon_en = 1'b1;

    while (!(sent == N_INST && take_cnt == exp_vd.size())) begin
      @(posedge clk);
      #2;
      if (in_fire) begin
        inst_valid_i = 1'b0;
        sent++;
      end
      // Random gaps between instructions
      if (!inst_valid_i && made < N_INST && next_rand() % 4 != 0) begin
        w = make_inst(made);
        model_inst(w);
        inst_i       = w;
        inst_valid_i = 1'b1;
        made++;
      end
      // Back-pressure in random stretches
      if (stall_left > 0) begin
        rt_ready_i = 1'b0;
        stall_left--;
      end else if (next_rand() % 16 == 0) begin
        rt_ready_i = 1'b0;
        stall_left = next_rand() % 24;
      end else begin
        rt_ready_i = 1'b1;
      end
      vxsat_clr_i = (next_rand() % 32 == 0);
    end

    rt_ready_i  = 1'b1;
    vxsat_clr_i = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    check_val("rt_valid_o", rt_valid_o, 1'b0);
    if (!saw_full) begin
      fail_run("inst_ready_o never fell while an instruction was waiting");
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: all.f
+incdir+.
vbe_pkg.sv
uop_if.sv
cmd_queue.sv
uop_decode.sv
vec_issue.sv
vec_regfile.sv
vec_alu.sv
vec_retire.sv
vec_backend.sv
tb_vec_backend.sv
